//--- Makefile
TOP := transmit_top_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f transmit_top.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

//--- source/channel_mux.sv
////////////////////////////////////////////////////////////
// Channel multiplexer
// Registers one generator sample for each output channel
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module channel_mux (
  input  logic                              dac_clk,
  input  logic                              arst_n_i,
  tx_config_if.chain                        cfg_i,
  input  transmit_pkg::sample_t             src_data_i [transmit_pkg::SOURCES],
  input  logic [transmit_pkg::SOURCES-1:0]  src_valid_i,
  output transmit_pkg::sample_t             data_o [transmit_pkg::CHANNELS],
  output logic [transmit_pkg::CHANNELS-1:0] valid_o
);

  always_ff @(posedge dac_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int ch = 0; ch < transmit_pkg::CHANNELS; ch++) begin
        data_o[ch] <= '0;
      end
      valid_o <= '0;
    end else begin
      // Any source may feed any output, including the same one twice
      for (int ch = 0; ch < transmit_pkg::CHANNELS; ch++) begin
        data_o[ch]  <= src_data_i[cfg_i.mux_sel[ch]];
        valid_o[ch] <= src_valid_i[cfg_i.mux_sel[ch]];
      end
    end
  end

endmodule

//--- source/dac_prescaler.sv
////////////////////////////////////////////////////////////
// DAC prescaler
// Fixed-point scaling with saturation, one register stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dac_prescaler (
  input  logic                              dac_clk,
  input  logic                              arst_n_i,
  tx_config_if.chain                        cfg_i,
  input  transmit_pkg::sample_t             data_i [transmit_pkg::CHANNELS],
  input  logic [transmit_pkg::CHANNELS-1:0] valid_i,
  output transmit_pkg::sample_t             data_o [transmit_pkg::CHANNELS],
  output logic [transmit_pkg::CHANNELS-1:0] valid_o
);

  for (genvar ch = 0; ch < transmit_pkg::CHANNELS; ch++) begin : g_chan
    // Full signed product, scale gets a zero sign bit
    logic signed [transmit_pkg::SAMPLE_WIDTH+transmit_pkg::SCALE_WIDTH:0] product;
    // Integer part, three bits wider than a sample
    logic signed [transmit_pkg::SAMPLE_WIDTH+transmit_pkg::SCALE_WIDTH
                  -transmit_pkg::SCALE_FRAC_BITS:0] shifted;
    transmit_pkg::sample_t clamped;

    assign product = data_i[ch] * $signed({1'b0, cfg_i.scale[ch]});

    // Upper slice equals an arithmetic shift, rounds toward minus infinity
    assign shifted = product[transmit_pkg::SAMPLE_WIDTH+transmit_pkg::SCALE_WIDTH:
                             transmit_pkg::SCALE_FRAC_BITS];

    ////////////////////////////////////////////////////////////
    // Saturation
    ////////////////////////////////////////////////////////////

    // In range when all bits above the sample's sign agree with it
    always_comb begin
      if (&shifted[$left(shifted):transmit_pkg::SAMPLE_WIDTH-1] ||
          ~|shifted[$left(shifted):transmit_pkg::SAMPLE_WIDTH-1]) begin
        clamped = shifted[transmit_pkg::SAMPLE_WIDTH-1:0];
      end else if (shifted[$left(shifted)]) begin
        clamped = {1'b1, {(transmit_pkg::SAMPLE_WIDTH-1){1'b0}}};
      end else begin
        clamped = {1'b0, {(transmit_pkg::SAMPLE_WIDTH-1){1'b1}}};
      end
    end

    always_ff @(posedge dac_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        data_o[ch]  <= '0;
        valid_o[ch] <= 1'b0;
      end else begin
        data_o[ch]  <= clamped;
        valid_o[ch] <= valid_i[ch];
      end
    end
  end

endmodule

//--- source/dds.sv
////////////////////////////////////////////////////////////
// DDS sine generator
// Phase accumulator per channel, quarter-wave table lookup
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dds (
  input  logic                              dac_clk,
  input  logic                              arst_n_i,
  tx_config_if.chain                        cfg_i,
  output transmit_pkg::sample_t             sample_o [transmit_pkg::CHANNELS],
  output logic [transmit_pkg::CHANNELS-1:0] valid_o
);

  for (genvar ch = 0; ch < transmit_pkg::CHANNELS; ch++) begin : g_chan
    transmit_pkg::phase_t  phase_q;
    logic                  valid_q;
    logic [1:0]            quadrant;
    // 16-entry table
    logic [3:0]            addr;
    transmit_pkg::sample_t quarter;

    always_ff @(posedge dac_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        phase_q <= '0;
        valid_q <= 1'b0;
      end else begin
        phase_q <= phase_q + cfg_i.dds_inc[ch];
        valid_q <= 1'b1;
      end
    end

    ////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////

    assign quadrant = phase_q[transmit_pkg::PHASE_BITS-1 -: 2];

    // Falling quarters read the table backwards
    assign addr = quadrant[0] ? ~phase_q[transmit_pkg::PHASE_BITS-3 -: 4]
                              :  phase_q[transmit_pkg::PHASE_BITS-3 -: 4];

    assign quarter = transmit_pkg::SINE_QUARTER[addr];

    // Second half of the wave is negative
    assign sample_o[ch] = quadrant[1] ? -quarter : quarter;
    assign valid_o[ch]  = valid_q;
  end

endmodule

//--- source/transmit_pkg.sv
////////////////////////////////////////////////////////////
// Transmit chain package
// Widths, sample types, register codes and the sine table
////////////////////////////////////////////////////////////

package transmit_pkg;

  localparam int CHANNELS        = 2;
  localparam int SAMPLE_WIDTH    = 16;
  localparam int PHASE_BITS      = 16;
  localparam int SCALE_WIDTH     = 18;
  localparam int SCALE_FRAC_BITS = 16;

  // DDS outputs first, triangle outputs after them
  localparam int SOURCES   = 2 * CHANNELS;
  localparam int SEL_WIDTH = $clog2(SOURCES);

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [PHASE_BITS-1:0]          phase_t;
  typedef logic [SCALE_WIDTH-1:0]         scale_t;
  typedef logic [SEL_WIDTH-1:0]           sel_t;

  // Configuration register select
  typedef enum logic [2:0] {
    CFG_DDS_INC,
    CFG_TRI_INC,
    CFG_MUX_SEL,
    CFG_SCALE,
    CFG_TRIG_MASK
  } cfg_reg_e;

  // First quarter of a sine, sampled at the centre of each entry
  localparam sample_t SINE_QUARTER [16] = '{
    16'sd1608,  16'sd4808,  16'sd7962,  16'sd11039,
    16'sd14010, 16'sd16846, 16'sd19519, 16'sd22005,
    16'sd24279, 16'sd26319, 16'sd28105, 16'sd29621,
    16'sd30852, 16'sd31785, 16'sd32412, 16'sd32728
  };

endpackage

//--- source/transmit_top.sv
////////////////////////////////////////////////////////////
// Transmit chain top level
// DDS and triangle sources, mux, prescaler and trigger out
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module transmit_top (
  input  logic                                  dac_clk,
  input  logic                                  arst_n_i,
  // Configuration writes
  input  logic                                  cfg_we_i,
  input  transmit_pkg::cfg_reg_e                cfg_reg_i,
  input  logic [$clog2(transmit_pkg::CHANNELS)-1:0] cfg_chan_i,
  input  logic [transmit_pkg::SCALE_WIDTH-1:0]  cfg_data_i,
  // DAC side
  output transmit_pkg::sample_t                 dac_data_o [transmit_pkg::CHANNELS],
  output logic [transmit_pkg::CHANNELS-1:0]     dac_valid_o,
  output logic                                  dac_trigger_o
);

  tx_config_if cfg_bus ();

  transmit_pkg::sample_t             dds_data [transmit_pkg::CHANNELS];
  logic [transmit_pkg::CHANNELS-1:0] dds_valid;
  transmit_pkg::sample_t             tri_data [transmit_pkg::CHANNELS];
  logic [transmit_pkg::CHANNELS-1:0] tri_valid;
  logic [transmit_pkg::CHANNELS-1:0] tri_triggers;
  transmit_pkg::sample_t             src_data [transmit_pkg::SOURCES];
  logic [transmit_pkg::SOURCES-1:0]  src_valid;
  transmit_pkg::sample_t             mux_data [transmit_pkg::CHANNELS];
  logic [transmit_pkg::CHANNELS-1:0] mux_valid;

  tx_config_regs u_regs (
    .dac_clk    (dac_clk),
    .arst_n_i   (arst_n_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_reg_i  (cfg_reg_i),
    .cfg_chan_i (cfg_chan_i),
    .cfg_data_i (cfg_data_i),
    .cfg_o      (cfg_bus)
  );

  ////////////////////////////////////////////////////////////
  // Generators
  ////////////////////////////////////////////////////////////

  dds u_dds (
    .dac_clk  (dac_clk),
    .arst_n_i (arst_n_i),
    .cfg_i    (cfg_bus),
    .sample_o (dds_data),
    .valid_o  (dds_valid)
  );

  triangle u_triangle (
    .dac_clk   (dac_clk),
    .arst_n_i  (arst_n_i),
    .cfg_i     (cfg_bus),
    .sample_o  (tri_data),
    .valid_o   (tri_valid),
    .trigger_o (tri_triggers)
  );

  // Mux sources, DDS channels then triangle channels
  for (genvar ch = 0; ch < transmit_pkg::CHANNELS; ch++) begin : g_src
    assign src_data[ch]                        = dds_data[ch];
    assign src_data[transmit_pkg::CHANNELS+ch] = tri_data[ch];
  end
  assign src_valid = {tri_valid, dds_valid};

  ////////////////////////////////////////////////////////////
  // Output path
  ////////////////////////////////////////////////////////////

  channel_mux u_mux (
    .dac_clk     (dac_clk),
    .arst_n_i    (arst_n_i),
    .cfg_i       (cfg_bus),
    .src_data_i  (src_data),
    .src_valid_i (src_valid),
    .data_o      (mux_data),
    .valid_o     (mux_valid)
  );

  dac_prescaler u_prescaler (
    .dac_clk  (dac_clk),
    .arst_n_i (arst_n_i),
    .cfg_i    (cfg_bus),
    .data_i   (mux_data),
    .valid_i  (mux_valid),
    .data_o   (dac_data_o),
    .valid_o  (dac_valid_o)
  );

  trigger_manager u_trigger (
    .dac_clk    (dac_clk),
    .arst_n_i   (arst_n_i),
    .cfg_i      (cfg_bus),
    .triggers_i (tri_triggers),
    .trigger_o  (dac_trigger_o)
  );

endmodule

//--- source/triangle.sv
////////////////////////////////////////////////////////////
// Triangle wave generator with a trigger on phase wrap
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module triangle (
  input  logic                              dac_clk,
  input  logic                              arst_n_i,
  tx_config_if.chain                        cfg_i,
  output transmit_pkg::sample_t             sample_o [transmit_pkg::CHANNELS],
  output logic [transmit_pkg::CHANNELS-1:0] valid_o,
  output logic [transmit_pkg::CHANNELS-1:0] trigger_o
);

  for (genvar ch = 0; ch < transmit_pkg::CHANNELS; ch++) begin : g_chan
    transmit_pkg::phase_t                  phase_q;
    logic                                  carry_q;
    logic                                  valid_q;
    logic [transmit_pkg::PHASE_BITS-2:0]   ramp;

    // Carry of the last add is kept next to the phase
    always_ff @(posedge dac_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        phase_q <= '0;
        carry_q <= 1'b0;
        valid_q <= 1'b0;
      end else begin
        {carry_q, phase_q} <= {1'b0, phase_q} + {1'b0, cfg_i.tri_inc[ch]};
        valid_q            <= 1'b1;
      end
    end

    // Rising ramp in the first half, falling in the second
    assign ramp = phase_q[transmit_pkg::PHASE_BITS-1] ? ~phase_q[transmit_pkg::PHASE_BITS-2:0]
                                                       :  phase_q[transmit_pkg::PHASE_BITS-2:0];

    // Doubled, minus 32768, which only flips the top bit
    assign sample_o[ch]  = {~ramp[transmit_pkg::PHASE_BITS-2], ramp[transmit_pkg::PHASE_BITS-3:0],
                            1'b0};
    assign valid_o[ch]   = valid_q;
    assign trigger_o[ch] = carry_q;
  end

endmodule

//--- source/trigger_manager.sv
////////////////////////////////////////////////////////////
// Trigger manager, masked OR of the channel triggers
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module trigger_manager (
  input  logic                              dac_clk,
  input  logic                              arst_n_i,
  tx_config_if.chain                        cfg_i,
  input  logic [transmit_pkg::CHANNELS-1:0] triggers_i,
  output logic                              trigger_o
);

  logic masked_any;

  // Only channels enabled in the mask can fire
  assign masked_any = |(triggers_i & cfg_i.trig_mask);

  always_ff @(posedge dac_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      trigger_o <= 1'b0;
    end else begin
      trigger_o <= masked_any;
    end
  end

endmodule

//--- source/tx_config_if.sv
////////////////////////////////////////////////////////////
// Held configuration of the transmit chain
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface tx_config_if;

  // Phase increments per channel
  transmit_pkg::phase_t dds_inc [transmit_pkg::CHANNELS];
  transmit_pkg::phase_t tri_inc [transmit_pkg::CHANNELS];

  // Source picked by each output channel
  transmit_pkg::sel_t   mux_sel [transmit_pkg::CHANNELS];

  // Unsigned fixed point, unity at 2**SCALE_FRAC_BITS
  transmit_pkg::scale_t scale   [transmit_pkg::CHANNELS];

  logic [transmit_pkg::CHANNELS-1:0] trig_mask;

  modport regs  (output dds_inc, tri_inc, mux_sel, scale, trig_mask);
  modport chain (input  dds_inc, tri_inc, mux_sel, scale, trig_mask);

endinterface

//--- source/tx_config_regs.sv
////////////////////////////////////////////////////////////
// Configuration register bank
// Decodes write strobes and holds the per-channel settings
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tx_config_regs (
  input  logic                                  dac_clk,
  input  logic                                  arst_n_i,
  input  logic                                  cfg_we_i,
  input  transmit_pkg::cfg_reg_e                cfg_reg_i,
  input  logic [$clog2(transmit_pkg::CHANNELS)-1:0] cfg_chan_i,
  input  logic [transmit_pkg::SCALE_WIDTH-1:0]  cfg_data_i,
  tx_config_if.regs                             cfg_o
);

  always_ff @(posedge dac_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int ch = 0; ch < transmit_pkg::CHANNELS; ch++) begin
        cfg_o.dds_inc[ch] <= '0;
        cfg_o.tri_inc[ch] <= '0;
        // Each channel starts on its own DDS
        cfg_o.mux_sel[ch] <= transmit_pkg::sel_t'(ch);
        cfg_o.scale[ch]   <= transmit_pkg::scale_t'(1) << transmit_pkg::SCALE_FRAC_BITS;
      end
      cfg_o.trig_mask <= '0;
    end else if (cfg_we_i) begin
      case (cfg_reg_i)
        transmit_pkg::CFG_DDS_INC:
          cfg_o.dds_inc[cfg_chan_i] <= cfg_data_i[transmit_pkg::PHASE_BITS-1:0];
        transmit_pkg::CFG_TRI_INC:
          cfg_o.tri_inc[cfg_chan_i] <= cfg_data_i[transmit_pkg::PHASE_BITS-1:0];
        transmit_pkg::CFG_MUX_SEL:
          cfg_o.mux_sel[cfg_chan_i] <= cfg_data_i[transmit_pkg::SEL_WIDTH-1:0];
        transmit_pkg::CFG_SCALE:
          cfg_o.scale[cfg_chan_i]   <= cfg_data_i;
        // Mask is global, channel number not used
        transmit_pkg::CFG_TRIG_MASK:
          cfg_o.trig_mask <= cfg_data_i[transmit_pkg::CHANNELS-1:0];
        default: begin
        end
      endcase
    end
  end

endmodule

//--- tests/transmit_assertions.sv
////////////////////////////////////////////////////////////
// Transmit chain assertions
// Reset quiet, trigger pulse spacing and sticky valid
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module transmit_assertions (
  input  logic                              dac_clk,
  input  logic                              arst_n_i,
  input  logic [transmit_pkg::CHANNELS-1:0] dac_valid_i,
  input  logic                              dac_trigger_i,
  input  logic [transmit_pkg::CHANNELS-1:0] tri_triggers_i
);

  int failure_count = 0;

  a_reset_quiet: assert property (
    @(posedge dac_clk) !arst_n_i |-> (dac_valid_i == '0 && !dac_trigger_i)
  ) else begin
    $error("DAC valid or trigger high while reset is asserted");
    failure_count++;
  end

  // Back-to-back pulses need a wrap in each of the two cycles before
  a_trigger_spacing: assert property (
    @(posedge dac_clk) disable iff (!arst_n_i)
    (dac_trigger_i && $past(dac_trigger_i)) |->
      ($past(|tri_triggers_i) && $past(|tri_triggers_i, 2))
  ) else begin
    $error("DAC trigger held high without a wrap in both cycles");
    failure_count++;
  end

  a_valid_sticky: assert property (
    @(posedge dac_clk) disable iff (!arst_n_i)
    (($past(dac_valid_i) & ~dac_valid_i) == '0)
  ) else begin
    $error("DAC valid dropped after it was raised");
    failure_count++;
  end

endmodule

bind transmit_top transmit_assertions u_assertions (
  .dac_clk        (dac_clk),
  .arst_n_i       (arst_n_i),
  .dac_valid_i    (dac_valid_o),
  .dac_trigger_i  (dac_trigger_o),
  .tri_triggers_i (tri_triggers)
);

//--- tests/transmit_checker.sv
////////////////////////////////////////////////////////////
// Transmit chain checker
// Cycle model of the chain, compared on every clock edge
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module transmit_checker (
  input  logic                                      dac_clk,
  input  logic                                      arst_n_i,
  input  logic                                      cfg_we_i,
  input  transmit_pkg::cfg_reg_e                    cfg_reg_i,
  input  logic [$clog2(transmit_pkg::CHANNELS)-1:0] cfg_chan_i,
  input  logic [transmit_pkg::SCALE_WIDTH-1:0]      cfg_data_i,
  input  transmit_pkg::sample_t                     dac_data_i [transmit_pkg::CHANNELS],
  input  logic [transmit_pkg::CHANNELS-1:0]         dac_valid_i,
  input  logic                                      dac_trigger_i,
  input  logic                                      done_i,
  output int                                        error_count_o
);

  localparam int CH = transmit_pkg::CHANNELS;
  localparam int PB = transmit_pkg::PHASE_BITS;
  localparam int RAMP_MAX = (1 << (PB - 1)) - 1;
  localparam longint SAMPLE_MAX = (64'sd1 <<< (transmit_pkg::SAMPLE_WIDTH - 1)) - 1;
  localparam longint SAMPLE_MIN = -(64'sd1 <<< (transmit_pkg::SAMPLE_WIDTH - 1));
  localparam transmit_pkg::scale_t UNITY =
    transmit_pkg::scale_t'(1) << transmit_pkg::SCALE_FRAC_BITS;

  // Configuration copy
  transmit_pkg::phase_t  dds_inc [CH];
  transmit_pkg::phase_t  tri_inc [CH];
  transmit_pkg::sel_t    mux_sel [CH];
  transmit_pkg::scale_t  scale   [CH];
  logic [CH-1:0]         trig_mask;

  // Generators
  transmit_pkg::phase_t  dds_phase [CH];
  transmit_pkg::phase_t  tri_phase [CH];
  logic [CH-1:0]         tri_carry;
  logic                  gen_valid;

  // Mux stage, then output stage
  transmit_pkg::sample_t mux_data [CH];
  logic [CH-1:0]         mux_valid;
  transmit_pkg::sel_t    mux_src  [CH];
  transmit_pkg::sample_t out_data [CH];
  logic [CH-1:0]         out_valid;
  string                 out_name [CH];
  logic                  trig_q;

  int   error_count  = 0;
  int   check_cycles = 0;
  logic summary_done = 1'b0;

  assign error_count_o = error_count;

  ////////////////////////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////////////////////////

  function automatic transmit_pkg::sample_t sine_sample(input transmit_pkg::phase_t phase);
    logic [1:0]            quadrant;
    logic [3:0]            index;
    transmit_pkg::sample_t value;
    quadrant = phase[PB-1 -: 2];
    index    = phase[PB-3 -: 4];
    // Odd quadrants walk back down the table
    if (quadrant[0]) begin
      index = 4'd15 - index;
    end
    value = transmit_pkg::SINE_QUARTER[index];
    if (quadrant[1]) begin
      value = -value;
    end
    return value;
  endfunction

  function automatic transmit_pkg::sample_t triangle_sample(input transmit_pkg::phase_t phase);
    int ramp;
    ramp = int'(phase[PB-2:0]);
    if (phase[PB-1]) begin
      ramp = RAMP_MAX - ramp;
    end
    return transmit_pkg::sample_t'(2 * ramp - (RAMP_MAX + 1));
  endfunction

  function automatic transmit_pkg::sample_t scale_sample(input transmit_pkg::sample_t sample,
                                                         input transmit_pkg::scale_t  factor);
    longint product;
    product = longint'(sample) * longint'(factor);
    product = product >>> transmit_pkg::SCALE_FRAC_BITS;
    if (product > SAMPLE_MAX) begin
      product = SAMPLE_MAX;
    end else if (product < SAMPLE_MIN) begin
      product = SAMPLE_MIN;
    end
    return transmit_pkg::sample_t'(product);
  endfunction

  function automatic string behavior_name(input transmit_pkg::sel_t src, input logic scaled);
    if (scaled) begin
      return "prescaler";
    end else if (int'(src) < CH) begin
      return "dds_sine";
    end
    return "triangle_mux";
  endfunction

  ////////////////////////////////////////////////////////////
  // Model update and compare
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input int ch, input int expected,
                                 input int actual);
    $display("FAILED %s ch%0d: expected %0d, actual %0d", name, ch, expected, actual);
    error_count++;
  endtask

  task automatic reset_model();
    for (int ch = 0; ch < CH; ch++) begin
      dds_inc[ch]   = '0;
      tri_inc[ch]   = '0;
      mux_sel[ch]   = transmit_pkg::sel_t'(ch);
      scale[ch]     = UNITY;
      dds_phase[ch] = '0;
      tri_phase[ch] = '0;
      mux_data[ch]  = '0;
      mux_src[ch]   = transmit_pkg::sel_t'(ch);
      out_data[ch]  = '0;
      out_name[ch]  = "reset_defaults";
    end
    trig_mask = '0;
    tri_carry = '0;
    gen_valid = 1'b0;
    mux_valid = '0;
    out_valid = '0;
    trig_q    = 1'b0;
  endtask

  task automatic apply_write();
    case (cfg_reg_i)
      transmit_pkg::CFG_DDS_INC:   dds_inc[cfg_chan_i] = cfg_data_i[PB-1:0];
      transmit_pkg::CFG_TRI_INC:   tri_inc[cfg_chan_i] = cfg_data_i[PB-1:0];
      transmit_pkg::CFG_MUX_SEL:   mux_sel[cfg_chan_i] = cfg_data_i[transmit_pkg::SEL_WIDTH-1:0];
      transmit_pkg::CFG_SCALE:     scale[cfg_chan_i]   = cfg_data_i;
      transmit_pkg::CFG_TRIG_MASK: trig_mask           = cfg_data_i[CH-1:0];
      default: begin
      end
    endcase
  endtask

  // Stages advance from the back so each one reads last cycle's state
  task automatic step_model();
    transmit_pkg::sample_t src [transmit_pkg::SOURCES];
    int sum;
    trig_q = |(tri_carry & trig_mask);
    for (int ch = 0; ch < CH; ch++) begin
      out_data[ch]  = scale_sample(mux_data[ch], scale[ch]);
      out_valid[ch] = mux_valid[ch];
      out_name[ch]  = behavior_name(mux_src[ch], scale[ch] != UNITY);
    end
    for (int ch = 0; ch < CH; ch++) begin
      src[ch]      = sine_sample(dds_phase[ch]);
      src[CH + ch] = triangle_sample(tri_phase[ch]);
    end
    for (int ch = 0; ch < CH; ch++) begin
      mux_data[ch]  = src[mux_sel[ch]];
      mux_valid[ch] = gen_valid;
      mux_src[ch]   = mux_sel[ch];
    end
    for (int ch = 0; ch < CH; ch++) begin
      sum           = int'(dds_phase[ch]) + int'(dds_inc[ch]);
      dds_phase[ch] = transmit_pkg::phase_t'(sum);
      sum           = int'(tri_phase[ch]) + int'(tri_inc[ch]);
      tri_carry[ch] = (sum >= (1 << PB));
      tri_phase[ch] = transmit_pkg::phase_t'(sum);
    end
    gen_valid = 1'b1;
    if (cfg_we_i) begin
      apply_write();
    end
  endtask

  task automatic compare_outputs();
    check_cycles++;
    for (int ch = 0; ch < CH; ch++) begin
      if (dac_data_i[ch] !== out_data[ch]) begin
        report_mismatch(out_name[ch], ch, int'(out_data[ch]), int'(dac_data_i[ch]));
      end
    end
    if (dac_valid_i !== out_valid) begin
      report_mismatch("reset_defaults valid", 0, int'(out_valid), int'(dac_valid_i));
    end
    if (dac_trigger_i !== trig_q) begin
      report_mismatch("trigger", 0, int'(trig_q), int'(dac_trigger_i));
    end
  endtask

  always @(posedge dac_clk) begin
    if (!done_i) begin
      if (!arst_n_i) begin
        if (dac_valid_i !== '0) begin
          report_mismatch("reset_defaults valid", 0, 0, int'(dac_valid_i));
        end
        if (dac_trigger_i !== 1'b0) begin
          report_mismatch("reset_defaults trigger", 0, 0, int'(dac_trigger_i));
        end
        reset_model();
      end else begin
        compare_outputs();
        step_model();
      end
    end else if (!summary_done) begin
      $display("Checker: %0d cycles compared, %0d errors", check_cycles, error_count);
      summary_done = 1'b1;
    end
  end

endmodule

//--- tests/transmit_top_tb.sv
////////////////////////////////////////////////////////////
// Transmit chain testbench
// Clock, reset, random configuration writes and watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module transmit_top_tb;

  localparam int RESET_CYCLES  = 10;
  localparam int PHASE1_CYCLES = 500;
  localparam int PHASE2_CYCLES = 500;
  localparam int PHASE3_CYCLES = 500;
  localparam int PHASE4_CYCLES = 1000;
  // All phases plus reset, then a margin of 200
  localparam int CYCLE_LIMIT   = RESET_CYCLES + PHASE1_CYCLES + PHASE2_CYCLES
                                 + PHASE3_CYCLES + PHASE4_CYCLES + 200;
  localparam logic [31:0] RANDOM_SEED = 32'hdc3a_d7dc;
  localparam int CHAN_WIDTH = $clog2(transmit_pkg::CHANNELS);

  logic                                     dac_clk;
  logic                                     arst_n_i;
  logic                                     cfg_we;
  transmit_pkg::cfg_reg_e                   cfg_reg;
  logic [CHAN_WIDTH-1:0]                    cfg_chan;
  logic [transmit_pkg::SCALE_WIDTH-1:0]     cfg_data;
  transmit_pkg::sample_t                    dac_data [transmit_pkg::CHANNELS];
  logic [transmit_pkg::CHANNELS-1:0]        dac_valid;
  logic                                     dac_trigger;
  logic                                     done;
  int                                       error_count;
  int                                       cycle_count;

  initial begin
    dac_clk = 1'b0;
    forever #2 dac_clk = ~dac_clk;
  end

  transmit_top u_dut (
    .dac_clk       (dac_clk),
    .arst_n_i      (arst_n_i),
    .cfg_we_i      (cfg_we),
    .cfg_reg_i     (cfg_reg),
    .cfg_chan_i    (cfg_chan),
    .cfg_data_i    (cfg_data),
    .dac_data_o    (dac_data),
    .dac_valid_o   (dac_valid),
    .dac_trigger_o (dac_trigger)
  );

  transmit_checker u_checker (
    .dac_clk       (dac_clk),
    .arst_n_i      (arst_n_i),
    .cfg_we_i      (cfg_we),
    .cfg_reg_i     (cfg_reg),
    .cfg_chan_i    (cfg_chan),
    .cfg_data_i    (cfg_data),
    .dac_data_i    (dac_data),
    .dac_valid_i   (dac_valid),
    .dac_trigger_i (dac_trigger),
    .done_i        (done),
    .error_count_o (error_count)
  );

  // Phase 2 only DDS, phase 3 adds triangle and mux, phase 4 everything
  function automatic transmit_pkg::cfg_reg_e pick_register(input int phase,
                                                           input logic [31:0] rnd);
    int unsigned pick;
    if (phase == 2) begin
      return transmit_pkg::CFG_DDS_INC;
    end
    pick = (phase == 3) ? rnd % 32'd3 : rnd % 32'd5;
    case (pick)
      0:       return transmit_pkg::CFG_DDS_INC;
      1:       return transmit_pkg::CFG_TRI_INC;
      2:       return transmit_pkg::CFG_MUX_SEL;
      3:       return transmit_pkg::CFG_SCALE;
      default: return transmit_pkg::CFG_TRIG_MASK;
    endcase
  endfunction

  task automatic run_phase(input int phase, input int cycles);
    logic [31:0] choice;
    logic [31:0] data;
    repeat (cycles) begin
      @(posedge dac_clk);
      choice = $urandom();
      data   = $urandom();
      // Roughly one write in eight cycles
      if (phase > 1 && choice[2:0] == 3'd0) begin
        cfg_we   <= 1'b1;
        cfg_reg  <= pick_register(phase, choice >> 3);
        cfg_chan <= data[31 -: CHAN_WIDTH];
        cfg_data <= data[transmit_pkg::SCALE_WIDTH-1:0];
      end else begin
        cfg_we <= 1'b0;
      end
    end
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge dac_clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Test failed");
    $finish;
  end

  initial begin : stimulus
    void'($urandom(RANDOM_SEED));
    arst_n_i = 1'b0;
    cfg_we   = 1'b0;
    cfg_reg  = transmit_pkg::CFG_DDS_INC;
    cfg_chan = '0;
    cfg_data = '0;
    done     = 1'b0;
    repeat (RESET_CYCLES) @(posedge dac_clk);
    arst_n_i <= 1'b1;
    run_phase(1, PHASE1_CYCLES);
    run_phase(2, PHASE2_CYCLES);
    run_phase(3, PHASE3_CYCLES);
    run_phase(4, PHASE4_CYCLES);
    @(posedge dac_clk);
    cfg_we <= 1'b0;
    done   <= 1'b1;
    // Checker prints its count line on the next edge
    repeat (2) @(posedge dac_clk);
    if (error_count == 0 && u_dut.u_assertions.failure_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- transmit_top.f
source/transmit_pkg.sv
source/tx_config_if.sv
source/tx_config_regs.sv
source/dds.sv
source/triangle.sv
source/channel_mux.sv
source/dac_prescaler.sv
source/trigger_manager.sv
source/transmit_top.sv
tests/transmit_assertions.sv
tests/transmit_checker.sv
tests/transmit_top_tb.sv
